// File: verilog/dcp_pkg.sv
package dcp_pkg;

    // Dump geometry
    localparam int dump_words = 8;                        // Words per line
    localparam int word_bytes = 4;                        // Address step per word
    localparam int hex_digits = 8;                        // Characters per word

    // Counter widths
    localparam int word_cnt_w = $clog2(dump_words + 1);   // Counts 0..dump_words
    localparam int char_cnt_w = $clog2(hex_digits + 2);   // Counts 0..hex_digits

    // ASCII
    localparam logic [7:0] ascii_space   = 8'h20;
    localparam logic [7:0] ascii_colon   = 8'h3A;
    localparam logic [7:0] ascii_cr      = 8'h0D;
    localparam logic [7:0] ascii_lf      = 8'h0A;
    localparam logic [7:0] ascii_zero    = 8'h30;         // Base of '0'..'9'
    localparam logic [7:0] ascii_upper_a = 8'h41;         // Base of 'A'..'F'

    // Receive link answer, valid with ack_rx
    typedef struct packed {
        logic [31:0] addr;                                // Number typed
        logic        empty;                               // Nothing typed
    } rx_rsp_t;

    // What the printer has to render
    typedef enum logic [1:0] {
        item_addr = 2'd0,                                 // Line address and colon
        item_data = 2'd1,                                 // Space and one word
        item_end  = 2'd2                                  // CR LF
    } item_kind_t;

    typedef struct packed {
        item_kind_t  kind;
        logic [31:0] value;                               // Unused for item_end
    } print_item_t;

endpackage

// File: verilog/dcp_addr_scan.sv
`timescale 1ns/1ps

module dcp_addr_scan (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start_D,       // Command strobe from decoder
    output logic             req_rx_D,      // Ask receiver for a number
    input  logic             ack_rx,
    input  dcp_pkg::rx_rsp_t rx_rsp,        // Valid with ack_rx
    input  logic [31:0]      next_addr,     // Continuation address
    output logic [31:0]      start_addr,
    output logic             addr_valid,    // One-cycle pulse
    output logic             busy,          // Whole command in flight
    input  logic             line_done      // Last byte acknowledged
);

    import dcp_pkg::*;

    logic        rsp_take;                  // Receiver answer this cycle
    logic [31:0] typed_addr;                // Typed number, word aligned

    assign rsp_take   = req_rx_D & ack_rx;
    assign typed_addr = rx_rsp.addr & ~32'(word_bytes - 1);

    // Command and request control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            req_rx_D   <= 1'b0;
            addr_valid <= 1'b0;
        end else begin
            addr_valid <= rsp_take;                    // One cycle after ack
            if (start_D && !busy) begin                // Start while busy dropped
                busy     <= 1'b1;
                req_rx_D <= 1'b1;                      // High one cycle after start
            end else if (rsp_take) begin
                req_rx_D <= 1'b0;                      // Low in cycle after ack
            end
            if (line_done) begin
                busy <= 1'b0;                          // Ready for next command
            end
        end
    end

    // Address choice, empty input continues the last dump
    always_ff @(posedge clk) begin
        if (rsp_take) begin
            start_addr <= rx_rsp.empty ? next_addr : typed_addr;
        end
    end

    // Open request stays inside the command that raised it
    a_one_req: assert property (@(posedge clk) disable iff (!rst_n)
        req_rx_D |-> busy)
        else $error("req_rx_D open outside a command");

    // Receiver answers only an open request
    a_ack_in_req: assert property (@(posedge clk) disable iff (!rst_n)
        ack_rx |-> req_rx_D)
        else $error("ack_rx without req_rx_D");

endmodule

// File: verilog/dcp_dump_seq.sv
`timescale 1ns/1ps

module dcp_dump_seq (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [31:0]          start_addr,
    input  logic                 addr_valid,   // Start of a dump
    output logic [31:0]          addr_D,       // Data memory address
    input  logic [31:0]          dout_dm,      // Word for last cycle's addr_D
    output dcp_pkg::print_item_t item,
    output logic                 item_valid,
    input  logic                 item_ready,
    output logic [31:0]          next_addr     // Start of the following dump
);

    import dcp_pkg::*;

    typedef enum logic [1:0] {
        s_idle,                                // Wait for an address
        s_hold,                                // Item held in item_q
        s_read,                                // Memory read cycle
        s_data                                 // Word offered straight from memory
    } state_t;

    state_t                state;
    print_item_t           item_q;             // Held item
    logic [31:0]           rd_addr;            // Next word address
    logic [word_cnt_w-1:0] word_cnt;           // Reads issued so far
    logic                  all_read;           // Every word of the line read

    assign all_read   = (word_cnt == word_cnt_w'(dump_words));
    assign addr_D     = rd_addr;               // Sampled in s_read only
    assign item_valid = (state == s_hold) || (state == s_data);

    // Fresh word goes out the cycle after its read
    always_comb begin
        if (state == s_data) begin
            item = '{kind: item_data, value: dout_dm};
        end else begin
            item = item_q;
        end
    end

    // Control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= s_idle;
            word_cnt  <= '0;
            next_addr <= '0;                   // First empty dump starts at 0
        end else begin
            case (state)
                s_idle: begin
                    if (addr_valid) begin
                        state    <= s_hold;    // Address item first
                        word_cnt <= '0;
                    end
                end
                s_hold: begin
                    if (item_ready) begin
                        if (item_q.kind == item_end) begin
                            state     <= s_idle;
                            next_addr <= rd_addr;  // Start plus 32
                        end else if (!all_read) begin
                            state <= s_read;   // Read one cycle after take
                        end
                    end
                end
                s_read: begin
                    state    <= s_data;
                    word_cnt <= word_cnt + 1'b1;
                end
                s_data: begin
                    if (item_ready && !all_read) begin
                        state <= s_read;       // Taken at once, keep going
                    end else begin
                        state <= s_hold;       // Park word or end item
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // Item and address registers
    always_ff @(posedge clk) begin
        case (state)
            s_idle: begin
                if (addr_valid) begin
                    item_q  <= '{kind: item_addr, value: start_addr};
                    rd_addr <= start_addr;
                end
            end
            s_hold: begin
                if (item_ready && item_q.kind == item_data && all_read) begin
                    item_q <= '{kind: item_end, value: 32'h0};
                end
            end
            s_read: rd_addr <= rd_addr + 32'(word_bytes);
            s_data: begin
                if (item_ready && all_read) begin
                    item_q <= '{kind: item_end, value: 32'h0};
                end else begin
                    item_q <= '{kind: item_data, value: dout_dm};  // Capture word
                end
            end
            default: ;
        endcase
    end

    // Offered item waits unchanged for the printer
    a_item_hold: assert property (@(posedge clk) disable iff (!rst_n)
        item_valid && !item_ready |=> item_valid && $stable(item))
        else $error("print item changed before it was taken");

endmodule

// File: verilog/dcp_hex_tx.sv
`timescale 1ns/1ps

module dcp_hex_tx (
    input  logic                 clk,
    input  logic                 rst_n,
    input  dcp_pkg::print_item_t item,
    input  logic                 item_valid,
    output logic                 item_ready,  // High only when idle
    output logic                 req_tx_D,    // Byte on dout_D
    input  logic                 ack_tx,
    output logic [7:0]           dout_D,
    output logic                 line_done    // Pulse after LF ack
);

    import dcp_pkg::*;

    logic                  active;            // Item being printed
    print_item_t           cur;               // Item, value shifts per digit
    logic [char_cnt_w-1:0] idx;               // Character within the item
    logic [char_cnt_w-1:0] last_idx;          // Final character of the item
    logic                  is_digit;          // Current character is hex
    logic [3:0]            nib;               // Most significant nibble left
    logic [7:0]            ch;                // Next byte to send
    logic                  byte_done;         // Byte acknowledged

    assign item_ready = !active;
    assign byte_done  = req_tx_D & ack_tx;
    assign nib        = cur.value[31:28];

    // Character for the current position
    always_comb begin
        is_digit = 1'b0;
        ch       = ascii_lf;
        last_idx = char_cnt_w'(hex_digits);   // Nine characters for addr/data
        case (cur.kind)
            item_addr: begin
                if (idx == char_cnt_w'(hex_digits)) begin
                    ch = ascii_colon;         // After the eight digits
                end else begin
                    is_digit = 1'b1;
                end
            end
            item_data: begin
                if (idx == '0) begin
                    ch = ascii_space;         // Separator first
                end else begin
                    is_digit = 1'b1;
                end
            end
            default: begin
                last_idx = char_cnt_w'(1);    // CR then LF
                ch       = (idx == '0) ? ascii_cr : ascii_lf;
            end
        endcase
        if (is_digit) begin
            if (nib < 4'd10) begin
                ch = ascii_zero + {4'h0, nib};
            end else begin
                ch = ascii_upper_a + {4'h0, nib} - 8'd10;  // Upper case A-F
            end
        end
    end

    // Byte sequencing, two cycles per byte at least
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active    <= 1'b0;
            req_tx_D  <= 1'b0;
            idx       <= '0;
            line_done <= 1'b0;
        end else begin
            line_done <= 1'b0;
            if (!active) begin
                if (item_valid) begin
                    active <= 1'b1;           // Take in one cycle
                    idx    <= '0;
                end
            end else if (!req_tx_D) begin
                req_tx_D <= 1'b1;             // Raise with byte loaded
            end else if (ack_tx) begin
                req_tx_D <= 1'b0;             // Low in cycle after ack
                idx      <= idx + 1'b1;
                if (idx == last_idx) begin
                    active    <= 1'b0;
                    line_done <= (cur.kind == item_end);
                end
            end
        end
    end

    // Item copy and output byte
    always_ff @(posedge clk) begin
        if (!active && item_valid) begin
            cur <= item;
        end else if (byte_done && is_digit) begin
            cur.value <= {cur.value[27:0], 4'h0};  // Next nibble to top
        end
        if (active && !req_tx_D) begin
            dout_D <= ch;                     // Same edge as req rise
        end
    end

    // Byte must not move under an open request
    a_dout_hold: assert property (@(posedge clk) disable iff (!rst_n)
        req_tx_D && !ack_tx |=> req_tx_D && $stable(dout_D))
        else $error("dout_D changed while req_tx_D was high");

endmodule

// File: verilog/dcp_dump_top.sv
`timescale 1ns/1ps

module dcp_dump_top (
    input  logic        clk,
    input  logic        rst_n,
    // Command
    input  logic        start_D,
    output logic        finish_D,
    // Receive link
    output logic        req_rx_D,
    input  logic        ack_rx,
    input  logic [31:0] din_rx,
    input  logic        flag_rx,     // Set for empty input
    // Transmit link
    output logic        req_tx_D,
    input  logic        ack_tx,
    output logic [7:0]  dout_D,
    // Data memory
    output logic [31:0] addr_D,
    input  logic [31:0] dout_dm
);

    import dcp_pkg::*;

    rx_rsp_t     rx_rsp;             // Receive answer bundled
    print_item_t item;
    logic        item_valid;
    logic        item_ready;
    logic [31:0] start_addr;
    logic [31:0] next_addr;          // Continuation, sequencer to scan
    logic        addr_valid;
    logic        busy;
    logic        line_done;

    assign rx_rsp   = '{addr: din_rx, empty: flag_rx};
    assign finish_D = line_done;     // End of command

    dcp_addr_scan u_scan (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_D    (start_D),
        .req_rx_D   (req_rx_D),
        .ack_rx     (ack_rx),
        .rx_rsp     (rx_rsp),
        .next_addr  (next_addr),
        .start_addr (start_addr),
        .addr_valid (addr_valid),
        .busy       (busy),
        .line_done  (line_done)
    );

    dcp_dump_seq u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_addr (start_addr),
        .addr_valid (addr_valid),
        .addr_D     (addr_D),
        .dout_dm    (dout_dm),
        .item       (item),
        .item_valid (item_valid),
        .item_ready (item_ready),
        .next_addr  (next_addr)
    );

    dcp_hex_tx u_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .item       (item),
        .item_valid (item_valid),
        .item_ready (item_ready),
        .req_tx_D   (req_tx_D),
        .ack_tx     (ack_tx),
        .dout_D     (dout_D),
        .line_done  (line_done)
    );

    // Line ends only inside a command the scan accepted
    a_finish_in_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        finish_D |-> busy)
        else $error("finish_D outside a command");

endmodule

// File: tests/tb_dcp_dump.sv
`timescale 1ns/1ps

module tb_dcp_dump;

    import dcp_pkg::*;

    localparam int clk_period   = 100;                          // ns
    localparam int num_cmds     = 20;
    localparam int line_bytes   = 83;                           // Address, 8 words, CR LF
    localparam int line_step    = dump_words * word_bytes;      // Continuation step
    localparam int limit_cycles = num_cmds * line_bytes * 10 + 4000;  // Worst pacing plus slack

    logic        clk;
    logic        rst_n;
    logic        start_D;
    logic        finish_D;
    logic        req_rx_D;
    logic        ack_rx;
    logic [31:0] din_rx;
    logic        flag_rx;
    logic        req_tx_D;
    logic        ack_tx;
    logic [7:0]  dout_D;
    logic [31:0] addr_D;
    logic [31:0] dout_dm;

    integer      seed       = 32'h1b19_ca70;
    logic [7:0]  tx_log[$];                                     // Acknowledged bytes
    logic [7:0]  exp_line[$];                                   // Model line
    logic [31:0] exp_start  = '0;                               // Model start of current dump
    logic [31:0] cont_addr  = '0;                               // Model continuation, 0 after reset
    int          rx_answers = 0;
    int          finish_cnt = 0;                                // finish_D pulses seen
    int          rx_req_cnt = 0;                                // req_rx_D rising edges

    dcp_dump_top dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_D  (start_D),
        .finish_D (finish_D),
        .req_rx_D (req_rx_D),
        .ack_rx   (ack_rx),
        .din_rx   (din_rx),
        .flag_rx  (flag_rx),
        .req_tx_D (req_tx_D),
        .ack_tx   (ack_tx),
        .dout_D   (dout_D),
        .addr_D   (addr_D),
        .dout_dm  (dout_dm)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Memory contents, every address bit mixed in
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        logic [31:0] h;
        h = a * 32'h9E37_79B1;
        h = h ^ (h >> 15) ^ {a[15:0], a[31:16]};
        return h + 32'h3C6E_F372;
    endfunction

    // Upper-case hex digit by table lookup
    function automatic logic [7:0] hex_char(input logic [3:0] n);
        logic [127:0] digit_chars;
        digit_chars = "0123456789ABCDEF";                       // '0' in the top byte
        return digit_chars[(15 - n) * 8 +: 8];
    endfunction

    // Expected text line for a dump starting at start
    task automatic build_line(input logic [31:0] start);
        logic [31:0] w;
        int          i;
        int          d;
        exp_line.delete();
        for (d = hex_digits - 1; d >= 0; d--) begin
            exp_line.push_back(hex_char(start[d*4 +: 4]));      // MSB first
        end
        exp_line.push_back(ascii_colon);
        for (i = 0; i < dump_words; i++) begin
            w = mem_word(start + 32'(i * word_bytes));
            exp_line.push_back(ascii_space);
            for (d = hex_digits - 1; d >= 0; d--) begin
                exp_line.push_back(hex_char(w[d*4 +: 4]));
            end
        end
        exp_line.push_back(ascii_cr);
        exp_line.push_back(ascii_lf);
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h got %h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value check on %s failed", name);
        end
    endtask

    // Synchronous read, word for last cycle's address
    initial begin : mem_model
        dout_dm = '0;
        forever begin
            @(posedge clk);
            dout_dm <= mem_word(addr_D);
        end
    end

    // Receiver, answers 1..5 cycles after the request
    initial begin : rx_model
        int          wait_cycles;
        logic        empty;
        logic [31:0] typed;
        ack_rx  = 1'b0;
        din_rx  = '0;
        flag_rx = 1'b0;
        forever begin
            @(posedge clk);
            if (req_rx_D === 1'b1) begin
                wait_cycles = 1 + ($unsigned($random(seed)) % 5);
                repeat (wait_cycles - 1) @(posedge clk);
                empty = (rx_answers == 0) || (($random(seed) & 3) == 0);  // First one empty
                typed = $random(seed) & 32'hFFFF_FFFC;          // Word aligned
                exp_start = empty ? cont_addr : typed;
                cont_addr = exp_start + 32'(line_step);
                rx_answers++;
                ack_rx  <= 1'b1;
                din_rx  <= typed;                               // Junk when empty
                flag_rx <= empty;
                @(posedge clk);
                ack_rx  <= 1'b0;
                flag_rx <= 1'b0;
            end
        end
    end

    // Transmitter, acks 0..6 cycles after the request and logs the byte
    initial begin : tx_model
        int wait_cycles;
        ack_tx = 1'b0;
        forever begin
            @(posedge clk);
            if (req_tx_D === 1'b1) begin
                wait_cycles = $unsigned($random(seed)) % 7;
                repeat (wait_cycles) @(posedge clk);
                tx_log.push_back(dout_D);
                ack_tx <= 1'b1;
                @(posedge clk);
                ack_tx <= 1'b0;
            end
        end
    end

    // Request edges, byte stability and line end
    initial begin : link_monitor
        logic       req_rx_q;
        logic       req_tx_q;
        logic [7:0] dout_q;
        req_rx_q = 1'b0;
        req_tx_q = 1'b0;
        dout_q   = '0;
        forever begin
            @(posedge clk);
            if (req_rx_D === 1'b1 && !req_rx_q) begin
                rx_req_cnt++;
            end
            if (req_tx_D === 1'b1 && req_tx_q) begin
                compare_value("dout_D", dout_q, dout_D);        // Held under open request
            end
            if (finish_D === 1'b1) begin
                finish_cnt++;
                compare_value("line_bytes", line_bytes, tx_log.size());  // After LF ack
                compare_value("last_byte", ascii_lf, tx_log[$]);
            end
            req_rx_q = (req_rx_D === 1'b1);
            req_tx_q = (req_tx_D === 1'b1);
            dout_q   = dout_D;
        end
    end

    initial begin : watchdog
        #(limit_cycles * clk_period);
        $display("Timeout: the dumps did not finish within %0d cycles", limit_cycles);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin : main_flow
        int cmd;
        int inject_at;
        int idle;
        int i;
        rst_n   = 1'b0;
        start_D = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (20) begin                                       // Quiet without a start
            @(posedge clk);
            compare_value("req_rx_D", 0, req_rx_D);
            compare_value("req_tx_D", 0, req_tx_D);
            compare_value("finish_D", 0, finish_D);
        end
        for (cmd = 0; cmd < num_cmds; cmd++) begin
            start_D <= 1'b1;
            @(posedge clk);
            start_D <= 1'b0;
            if (cmd % 2 == 1) begin                             // Stray start mid-dump
                inject_at = $unsigned($random(seed)) % 70;
                while (tx_log.size() < inject_at) begin
                    @(posedge clk);
                end
                @(posedge clk);
                start_D <= 1'b1;
                @(posedge clk);
                start_D <= 1'b0;
            end
            while (finish_cnt == cmd) begin
                @(posedge clk);
            end
            build_line(exp_start);
            compare_value("line_bytes", line_bytes, tx_log.size());
            for (i = 0; i < line_bytes; i++) begin
                compare_value("dout_D", exp_line[i], tx_log[i]);
            end
            $display("dump %0d from %h done", cmd, exp_start);
            tx_log.delete();
            idle = 1 + ($unsigned($random(seed)) % 4);
            repeat (idle) @(posedge clk);
            compare_value("finish_count", cmd + 1, finish_cnt);  // One pulse per command
            compare_value("rx_requests", cmd + 1, rx_req_cnt);   // Stray start ignored
        end
        compare_value("extra_tx_bytes", 0, tx_log.size());
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: dcp_dump.f
verilog/dcp_pkg.sv
verilog/dcp_addr_scan.sv
verilog/dcp_dump_seq.sv
verilog/dcp_hex_tx.sv
verilog/dcp_dump_top.sv
tests/tb_dcp_dump.sv

// File: Bender.yml
package:
  name: dcp_dump

dependencies: {}

sources:
  # Design, package first
  - files:
      - verilog/dcp_pkg.sv
      - verilog/dcp_addr_scan.sv
      - verilog/dcp_dump_seq.sv
      - verilog/dcp_hex_tx.sv
      - verilog/dcp_dump_top.sv

  # Testbench
  - target: test
    files:
      - tests/tb_dcp_dump.sv
